//--- flist.f
+incdir+include
hw/core_pkg.sv
hw/setting_reg.sv
hw/misc_ctrl.sv
hw/vita_timekeeper.sv
hw/readback_mux.sv
hw/radio_ctrl_core.sv
tests/tb_radio_ctrl.sv

//--- hw/core_pkg.sv
/*
 * Radio control core types
 * Settings bus words, VITA time, LED vector and the enums
 * for the timekeeper FSM and the readback selector
 */
`include "core_defs.svh"

package core_pkg;

   // Settings bus
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Free running tick count
   typedef logic [63:0] vita_time_t;

   typedef logic [7:0]  led_t;

   // Timekeeper FSM
   typedef enum logic {
      TIME_IDLE  = 1'b0,
      TIME_ARMED = 1'b1
   } time_state_e;

   // Readback word select, other codes read as zero
   typedef enum logic [`RB_ADDR_W-1:0] {
      RB_COMPAT  = 4'd0,
      RB_TIME_HI = 4'd1,
      RB_TIME_LO = 4'd2,
      RB_PPS_HI  = 4'd3,
      RB_PPS_LO  = 4'd4,
      RB_STATUS  = 4'd5
   } rb_word_e;

endpackage

//--- hw/misc_ctrl.sv
/*
 * Misc control registers
 * SERDES and ADC enables, PHY reset and the LED source mux
 * that picks software or hardware status bit by bit
 */
`timescale 1ns/100ps
`include "core_defs.svh"

module misc_ctrl
   import core_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   input  logic      run_tx_i,
   input  logic      run_rx_i,
   input  logic      clk_status_i,
   input  logic      serdes_link_up_i,
   input  logic      good_sync_i,
   output logic      ser_enable_o,
   output logic      ser_prbsen_o,
   output logic      ser_loopen_o,
   output logic      ser_rx_en_o,
   output logic      adc_oe_a_o,
   output logic      adc_on_a_o,
   output logic      adc_oe_b_o,
   output logic      adc_on_b_o,
   output logic      phy_reset_n_o,
   output led_t      leds_o
);

   logic [3:0] serdes_bits;
   logic [3:0] adc_bits;
   logic       phy_reset;
   led_t       led_sw;
   led_t       led_src;
   led_t       led_hw;

   //////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////
   setting_reg #(.SR_ADDR(set_addr_t'(`SR_MISC + `SR_SERDES_OFS)), .WIDTH(4)) sr_serdes (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(serdes_bits), .changed_o());

   setting_reg #(.SR_ADDR(set_addr_t'(`SR_MISC + `SR_ADC_OFS)), .WIDTH(4)) sr_adc (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(adc_bits), .changed_o());

   setting_reg #(.SR_ADDR(set_addr_t'(`SR_MISC + `SR_LED_SW_OFS)), .WIDTH(8)) sr_led_sw (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_sw), .changed_o());

   setting_reg #(.SR_ADDR(set_addr_t'(`SR_MISC + `SR_PHY_OFS)), .WIDTH(1)) sr_phy (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(phy_reset), .changed_o());

   setting_reg #(
      .SR_ADDR(set_addr_t'(`SR_MISC + `SR_LED_SRC_OFS)),
      .WIDTH(8),
      .AT_RESET(`LED_SRC_RESET)
   ) sr_led_src (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .value_o(led_src), .changed_o());

   // Pin unpacking, MSB first
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_bits;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}       = adc_bits;
   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset;

   //////////////////////////////////////////////////
   // LEDs
   //////////////////////////////////////////////////
   // Link LED only once time is in sync
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   // Source bit 1 = hardware, 0 = software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- hw/radio_ctrl_core.sv
/*
 * Radio control core
 * Settings bus registers, VITA timekeeper and readback
 */
`timescale 1ns/100ps

module radio_ctrl_core
   import core_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,
   // Settings bus
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   // Readback
   input  logic      rb_stb_i,
   input  rb_word_e  rb_addr_i,
   output set_data_t rb_data_o,
   output logic      rb_valid_o,
   // Status and timing
   input  logic      pps_i,
   input  logic      run_tx_i,
   input  logic      run_rx_i,
   input  logic      clk_status_i,
   input  logic      serdes_link_up_i,
   input  logic      button_i,
   output logic      pps_int_o,
   // Board control
   output logic      ser_enable_o,
   output logic      ser_prbsen_o,
   output logic      ser_loopen_o,
   output logic      ser_rx_en_o,
   output logic      adc_oe_a_o,
   output logic      adc_on_a_o,
   output logic      adc_oe_b_o,
   output logic      adc_on_b_o,
   output logic      phy_reset_n_o,
   output led_t      leds_o
);

   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   misc_ctrl misc_ctrl0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .good_sync_i(good_sync),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   vita_timekeeper timekeeper0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o), .good_sync_o(good_sync));

   readback_mux readback0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rb_stb_i(rb_stb_i), .rb_addr_i(rb_addr_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .good_sync_i(good_sync), .button_i(button_i),
      .rb_data_o(rb_data_o), .rb_valid_o(rb_valid_o));

endmodule

//--- hw/readback_mux.sv
/*
 * Readback mux
 * Registers the selected word one cycle after the read strobe
 */
`timescale 1ns/100ps
`include "core_defs.svh"

module readback_mux
   import core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       rb_stb_i,
   input  rb_word_e   rb_addr_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       good_sync_i,
   input  logic       button_i,
   output set_data_t  rb_data_o,
   output logic       rb_valid_o
);

   set_data_t status_word;
   set_data_t rb_word;

   // Link, clock, sync, button from bit 0 up
   assign status_word = {28'd0, button_i, good_sync_i, clk_status_i, serdes_link_up_i};

   //////////////////////////////////////////////////
   // Word select
   //////////////////////////////////////////////////
   always_comb begin
      case (rb_addr_i)
         RB_COMPAT:  rb_word = `COMPAT_NUM;
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         RB_STATUS:  rb_word = status_word;
         default:    rb_word = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // Output registers
   //////////////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         rb_valid_o <= 1'b0;
      else
         rb_valid_o <= rb_stb_i;
   end

   // Time words are the counter value at the strobe edge
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i)
         rb_data_o <= rb_word;
   end

   a_rb_valid_lag: assert property (@(posedge dsp_clk) disable iff (por_rst)
      rb_valid_o == $past(rb_stb_i));

endmodule

//--- hw/setting_reg.sv
/*
 * Settings register
 * Loads the low WIDTH bits of the bus data on a matching strobe
 */
`timescale 1ns/100ps

module setting_reg
   import core_pkg::*;
#(
   parameter set_addr_t        SR_ADDR  = '0,
   parameter int               WIDTH    = 8,
   parameter logic [WIDTH-1:0] AT_RESET = '0
) (
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic             set_stb_i,
   input  set_addr_t        set_addr_i,
   input  set_data_t        set_data_i,
   output logic [WIDTH-1:0] value_o,
   output logic             changed_o
);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         value_o   <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= 1'b0;
         // Only our own address is taken
         if (set_stb_i && (set_addr_i == SR_ADDR)) begin
            value_o   <= set_data_i[WIDTH-1:0];
            changed_o <= 1'b1;
         end
      end
   end

endmodule

//--- hw/vita_timekeeper.sv
/*
 * VITA timekeeper
 * 64-bit tick counter with immediate or PPS timed load,
 * PPS synchronizer and time latch on every PPS edge
 */
`timescale 1ns/100ps
`include "core_defs.svh"

module vita_timekeeper
   import core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       good_sync_o
);

   localparam set_addr_t ADDR_HI   = set_addr_t'(`SR_TIME64 + `TIME_HI_OFS);
   localparam set_addr_t ADDR_LO   = set_addr_t'(`SR_TIME64 + `TIME_LO_OFS);
   localparam set_addr_t ADDR_CTRL = set_addr_t'(`SR_TIME64 + `TIME_CTRL_OFS);

   logic        hi_wr;
   logic        lo_wr;
   logic        ctrl_wr;
   set_data_t   time_hi;
   set_data_t   time_lo;
   logic        load_now;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_det;
   logic        load_imm;
   logic        load_pps;
   time_state_e state;
   vita_time_t  time_next;

   //////////////////////////////////////////////////
   // Settings decode and staging
   //////////////////////////////////////////////////
   assign hi_wr   = set_stb_i && (set_addr_i == ADDR_HI);
   assign lo_wr   = set_stb_i && (set_addr_i == ADDR_LO);
   assign ctrl_wr = set_stb_i && (set_addr_i == ADDR_CTRL);

   always_ff @(posedge dsp_clk) begin
      if (hi_wr)
         time_hi <= set_data_i;
      if (lo_wr)
         time_lo <= set_data_i;
      if (ctrl_wr)
         load_now <= set_data_i[0];
   end

   //////////////////////////////////////////////////
   // PPS input
   //////////////////////////////////////////////////
   // Two flop sync, third flop for the edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_det = pps_sync & ~pps_dly;

   //////////////////////////////////////////////////
   // Load control
   //////////////////////////////////////////////////
   // Lower word bypasses the stage on immediate load
   assign load_imm = lo_wr && load_now;
   assign load_pps = (state == TIME_ARMED) && pps_det && !load_imm;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state       <= TIME_IDLE;
         good_sync_o <= 1'b0;
      end else begin
         case (state)
            TIME_IDLE: begin
               if (lo_wr && !load_now)
                  state <= TIME_ARMED;
            end
            TIME_ARMED: begin
               if (load_imm) begin
                  state <= TIME_IDLE;
               end else if (load_pps) begin
                  state       <= TIME_IDLE;
                  good_sync_o <= 1'b1;
               end
            end
            default: state <= TIME_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Counter and PPS latch
   //////////////////////////////////////////////////
   always_comb begin
      if (load_imm)
         time_next = {time_hi, set_data_i};
      else if (load_pps)
         time_next = {time_hi, time_lo};
      else
         time_next = vita_time_o + 64'd1;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_int_o       <= 1'b0;
      end else begin
         vita_time_o <= time_next;
         pps_int_o   <= pps_det;
         // Latch sees the loaded value on a sync edge
         if (pps_det)
            vita_time_pps_o <= time_next;
      end
   end

   // Sync stays until the next reset
   a_good_sync_sticky: assert property (@(posedge dsp_clk) disable iff (por_rst)
      good_sync_o |=> good_sync_o);

   a_time_step: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(load_imm || load_pps) |=> (vita_time_o == $past(vita_time_o) + 64'd1));

endmodule

//--- include/core_defs.svh
/*
 * Radio control core register map
 * Settings bus bases and offsets, compatibility number and
 * reset values shared by the control blocks
 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

//////////////////////////////////////////////////
// Misc control registers
//////////////////////////////////////////////////
`define SR_MISC         0
`define SR_SERDES_OFS   1
`define SR_ADC_OFS      2
`define SR_LED_SW_OFS   3
`define SR_PHY_OFS      4
`define SR_LED_SRC_OFS  6

// LED bits 1 to 4 follow hardware status after reset
`define LED_SRC_RESET   8'h1E

//////////////////////////////////////////////////
// VITA timekeeper registers
//////////////////////////////////////////////////
`define SR_TIME64       10
// Upper word, staged only
`define TIME_HI_OFS     0
// Lower word, a write here starts the load
`define TIME_LO_OFS     1
// Bit 0 set for immediate load, clear for next PPS
`define TIME_CTRL_OFS   2

//////////////////////////////////////////////////
// Readback
//////////////////////////////////////////////////
// Major and minor revision
`define COMPAT_NUM      {16'd10, 16'd0}
`define RB_ADDR_W       4

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the radio control core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f flist.f \
   --top-module tb_radio_ctrl \
   -Mdir obj_dir \
   -o sim_radio_ctrl

./obj_dir/sim_radio_ctrl > sim.log
cat sim.log

# The testbench exits cleanly either way, so the log decides
if grep -qx "all tests passed" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- tests/tb_radio_ctrl.sv
/*
 * Radio control core testbench
 * Directed tests of the settings registers, LED mux,
 * readback mux and the VITA time loads
 */
`timescale 1ns/100ps
`include "core_defs.svh"

module tb_radio_ctrl
   import core_pkg::*;
();

   logic      dsp_clk;
   logic      por_rst;
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;
   logic      rb_stb;
   rb_word_e  rb_addr;
   set_data_t rb_data;
   logic      rb_valid;
   logic      pps;
   logic      run_tx;
   logic      run_rx;
   logic      clk_status;
   logic      serdes_link_up;
   logic      button;
   logic      pps_int;
   logic      ser_enable;
   logic      ser_prbsen;
   logic      ser_loopen;
   logic      ser_rx_en;
   logic      adc_oe_a;
   logic      adc_on_a;
   logic      adc_oe_b;
   logic      adc_on_b;
   logic      phy_reset_n;
   led_t      leds;

   int        checks;
   int        errors;
   int        tests_run;
   int        mark_checks;
   int        mark_errors;
   set_data_t imm_hi;

   radio_ctrl_core dut0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .rb_stb_i(rb_stb), .rb_addr_i(rb_addr), .rb_data_o(rb_data), .rb_valid_o(rb_valid),
      .pps_i(pps), .run_tx_i(run_tx), .run_rx_i(run_rx), .clk_status_i(clk_status),
      .serdes_link_up_i(serdes_link_up), .button_i(button), .pps_int_o(pps_int),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen),
      .ser_loopen_o(ser_loopen), .ser_rx_en_o(ser_rx_en),
      .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds));

   // 100 ns clock
   always #50 dsp_clk = ~dsp_clk;

   //////////////////////////////////////////////////
   // Bus and status drivers
   //////////////////////////////////////////////////
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge dsp_clk);
      set_stb = 1'b0;
   endtask

   task automatic read_word(input rb_word_e addr, output set_data_t data);
      int waited;
      waited = 0;
      @(negedge dsp_clk);
      rb_stb  = 1'b1;
      rb_addr = addr;
      @(negedge dsp_clk);
      rb_stb = 1'b0;
      while (!rb_valid && waited < 16) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (rb_valid) begin
         data = rb_data;
      end else begin
         errors++;
         $display("readback of %s never returned valid within 16 cycles", addr.name());
         data = '0;
      end
   endtask

   // Settles for one cycle before anything is sampled
   task automatic drive_status(input logic tx, input logic rx, input logic clk_ok,
                               input logic link);
      @(negedge dsp_clk);
      run_tx         = tx;
      run_rx         = rx;
      clk_status     = clk_ok;
      serdes_link_up = link;
      @(negedge dsp_clk);
   endtask

   //////////////////////////////////////////////////
   // Compare and reference model
   //////////////////////////////////////////////////
   task automatic check_word(input string name, input set_data_t expected,
                             input set_data_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      end
   endtask

   task automatic check_leds(input string name, input led_t expected, input led_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   // Hardware LED bits 4 to 1 with the link bit gated by sync
   function automatic led_t expected_leds(input led_t src, input led_t sw, input logic tx,
                                          input logic rx, input logic clk_ok,
                                          input logic link, input logic sync);
      led_t hw;
      hw    = '0;
      hw[4] = tx;
      hw[3] = rx;
      hw[2] = clk_ok;
      hw[1] = link & sync;
      return (src & hw) | (~src & sw);
   endfunction

   task automatic report_test(input string name);
      tests_run++;
      if (errors == mark_errors)
         $display("test %s ok, %0d checks", name, checks - mark_checks);
      else
         $display("test %s: %0d of %0d checks wrong", name, errors - mark_errors,
                  checks - mark_checks);
      mark_checks = checks;
      mark_errors = errors;
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////
   task automatic verify_reset_values();
      set_data_t word;
      drive_status(1'b1, 1'b1, 1'b1, 1'b1);
      read_word(RB_COMPAT, word);
      // Major 10 in the upper half and minor 0 below
      check_word("compat", 32'h000a_0000, word);
      check_word("serdes_adc", 32'd0, {24'd0, ser_enable, ser_prbsen, ser_loopen, ser_rx_en,
                                       adc_oe_a, adc_on_a, adc_oe_b, adc_on_b});
      check_bit("phy_reset_n", 1'b1, phy_reset_n);
      // No sync yet so the link LED stays off
      check_leds("reset_leds", 8'h1C, leds);
      report_test("reset_values");
   endtask

   task automatic exercise_misc_regs();
      logic [31:0] rnd;
      logic [3:0]  serdes_val;
      logic [3:0]  adc_val;
      rnd        = $urandom;
      serdes_val = rnd[3:0];
      adc_val    = rnd[7:4];
      write_setting(set_addr_t'(`SR_MISC + `SR_SERDES_OFS), {28'd0, serdes_val});
      check_bit("ser_enable", serdes_val[3], ser_enable);
      check_bit("ser_prbsen", serdes_val[2], ser_prbsen);
      check_bit("ser_loopen", serdes_val[1], ser_loopen);
      check_bit("ser_rx_en", serdes_val[0], ser_rx_en);
      write_setting(set_addr_t'(`SR_MISC + `SR_ADC_OFS), {28'd0, adc_val});
      check_bit("adc_oe_a", adc_val[3], adc_oe_a);
      check_bit("adc_on_a", adc_val[2], adc_on_a);
      check_bit("adc_oe_b", adc_val[1], adc_oe_b);
      check_bit("adc_on_b", adc_val[0], adc_on_b);
      write_setting(set_addr_t'(`SR_MISC + `SR_PHY_OFS), 32'd1);
      check_bit("phy_reset_n", 1'b0, phy_reset_n);
      report_test("misc_regs");
   endtask

   task automatic sweep_led_mux();
      logic [31:0] rnd;
      led_t        sw;
      led_t        src;
      for (int i = 0; i < 8; i++) begin
         rnd = $urandom;
         sw  = rnd[7:0];
         src = rnd[15:8];
         drive_status(rnd[16], rnd[17], rnd[18], rnd[19]);
         write_setting(set_addr_t'(`SR_MISC + `SR_LED_SW_OFS), {24'd0, sw});
         write_setting(set_addr_t'(`SR_MISC + `SR_LED_SRC_OFS), {24'd0, src});
         check_leds("led_mux", expected_leds(src, sw, rnd[16], rnd[17], rnd[18], rnd[19],
                    1'b0), leds);
      end
      // Back to the reset routing
      write_setting(set_addr_t'(`SR_MISC + `SR_LED_SW_OFS), 32'd0);
      write_setting(set_addr_t'(`SR_MISC + `SR_LED_SRC_OFS), {24'd0, `LED_SRC_RESET});
      report_test("led_mux");
   endtask

   task automatic load_time_now();
      set_data_t t1;
      set_data_t t2;
      set_data_t word;
      imm_hi = $urandom;
      write_setting(set_addr_t'(`SR_TIME64 + `TIME_CTRL_OFS), 32'd1);
      write_setting(set_addr_t'(`SR_TIME64 + `TIME_HI_OFS), imm_hi);
      write_setting(set_addr_t'(`SR_TIME64 + `TIME_LO_OFS), 32'd0);
      read_word(RB_TIME_HI, word);
      check_word("time_hi_now", imm_hi, word);
      read_word(RB_TIME_LO, t1);
      read_word(RB_TIME_LO, t2);
      check_bit("time_lo_rising", 1'b1, t2 > t1);
      report_test("immediate_load");
   endtask

   task automatic load_time_on_pps();
      set_data_t pps_hi;
      set_data_t word;
      int        waited;
      logic      seen;
      do
         pps_hi = $urandom;
      while (pps_hi == imm_hi);
      drive_status(1'b1, 1'b1, 1'b1, 1'b1);
      button = 1'b1;
      write_setting(set_addr_t'(`SR_TIME64 + `TIME_CTRL_OFS), 32'd0);
      write_setting(set_addr_t'(`SR_TIME64 + `TIME_HI_OFS), pps_hi);
      write_setting(set_addr_t'(`SR_TIME64 + `TIME_LO_OFS), 32'd0);
      // Armed only so the counter keeps the old upper word
      read_word(RB_TIME_HI, word);
      check_word("time_hi_armed", imm_hi, word);
      // Sync bit still low while armed
      read_word(RB_STATUS, word);
      check_word("status_armed", {28'd0, 1'b1, 1'b0, 1'b1, 1'b1}, word);
      pps    = 1'b1;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < 20) begin
         @(negedge dsp_clk);
         waited++;
         if (pps_int)
            seen = 1'b1;
      end
      if (!seen) begin
         errors++;
         $display("pps_int_o did not pulse within 20 cycles of the PPS edge");
      end
      pps = 1'b0;
      read_word(RB_TIME_HI, word);
      check_word("time_hi_pps", pps_hi, word);
      read_word(RB_PPS_HI, word);
      check_word("pps_latch_hi", pps_hi, word);
      read_word(RB_STATUS, word);
      check_word("status", {28'd0, 1'b1, 1'b1, 1'b1, 1'b1}, word);
      check_leds("synced_leds", expected_leds(`LED_SRC_RESET, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1,
                 1'b1), leds);
      report_test("timed_load");
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      void'($urandom(32'hcecf3e85));
      checks         = 0;
      errors         = 0;
      tests_run      = 0;
      mark_checks    = 0;
      mark_errors    = 0;
      imm_hi         = '0;
      dsp_clk        = 1'b0;
      por_rst        = 1'b1;
      set_stb        = 1'b0;
      set_addr       = '0;
      set_data       = '0;
      rb_stb         = 1'b0;
      rb_addr        = RB_COMPAT;
      pps            = 1'b0;
      run_tx         = 1'b0;
      run_rx         = 1'b0;
      clk_status     = 1'b0;
      serdes_link_up = 1'b0;
      button         = 1'b0;
      repeat (5) @(negedge dsp_clk);
      por_rst = 1'b0;

      verify_reset_values();
      exercise_misc_regs();
      sweep_led_mux();
      load_time_now();
      load_time_on_pps();

      $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
